//--- design/comb_pkg.sv
package comb_pkg;

  ////////////////////
  // Data path
  ////////////////////

  // Samples and gain share one signed width
  localparam int SAMPLE_W = 16;

  // Fractional bits of the gain, 1 << Q_BITS is unity
  localparam int Q_BITS = 12;

  ////////////////////
  // Delay line
  ////////////////////

  localparam int ADDR_W    = 6;
  localparam int RAM_DEPTH = 1 << ADDR_W;

  // Legal delays run 1 to RAM_DEPTH, one bit wider than an address
  localparam int DELAY_W = ADDR_W + 1;

  ////////////////////
  // State types
  ////////////////////

  // Read-pointer tracker
  typedef enum logic [1:0] {
    PTR_IDLE,
    PTR_DIFF,
    PTR_WRAP
  } ptr_state_t;

  // Per-sample comb engine loop
  typedef enum logic [1:0] {
    RD_REQ,
    RD_WAIT,
    WAIT_X,
    WR_BACK
  } comb_state_t;

endpackage

//--- design/delay_pointer.sv
module delay_pointer import comb_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [DELAY_W-1:0] delay,
  input  logic               delay_load,
  input  logic               wr_en,
  output logic [ADDR_W-1:0]  ptr_addr,
  output logic               ptr_busy
);

  ptr_state_t state;

  logic        [DELAY_W-1:0] delay_q;
  logic        [DELAY_W-1:0] delay_pend;
  logic signed [DELAY_W:0]   delta;
  logic        [ADDR_W-1:0]  step;

  // Every write to the delay line moves the read side along with it
  assign step = {{(ADDR_W-1){1'b0}}, wr_en};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= PTR_IDLE;
      ptr_addr   <= '0;
      ptr_busy   <= 1'b0;
      delay_q    <= '0;
      delay_pend <= '0;
      delta      <= '0;
    end else begin
      case (state)
        PTR_IDLE: begin
          ptr_addr <= ptr_addr + step;
          ptr_busy <= delay_load;
          if (delay_load) begin
            delay_pend <= delay;
            state      <= PTR_DIFF;
          end
        end

        // Positive delta means more delay, so the pointer steps back
        PTR_DIFF: begin
          ptr_addr <= ptr_addr + step;
          ptr_busy <= 1'b1;
          delta    <= $signed({1'b0, delay_pend}) - $signed({1'b0, delay_q});
          delay_q  <= delay_pend;
          state    <= PTR_WRAP;
        end

        // Truncation to ADDR_W bits gives the wrap modulo the depth
        PTR_WRAP: begin
          ptr_addr <= ptr_addr - delta[ADDR_W-1:0] + step;
          ptr_busy <= 1'b1;
          state    <= PTR_IDLE;
        end

        default: begin
          state <= PTR_IDLE;
        end
      endcase
    end
  end

endmodule

//--- design/comb_engine.sv
module comb_engine import comb_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,

  // Sample stream
  input  logic signed [SAMPLE_W-1:0] x,
  input  logic                       x_valid,
  input  logic signed [SAMPLE_W-1:0] gain,
  output logic signed [SAMPLE_W-1:0] y,
  output logic                       y_valid,

  // Pointer tracker
  input  logic        [ADDR_W-1:0]   ptr_addr,
  input  logic                       ptr_busy,

  // Delay RAM read port
  output logic        [ADDR_W-1:0]   rd_addr,
  output logic                       rd_en,
  input  logic signed [SAMPLE_W-1:0] rd_data,
  input  logic                       rd_valid,

  // Delay RAM write port
  output logic        [ADDR_W-1:0]   wr_addr,
  output logic signed [SAMPLE_W-1:0] wr_data,
  output logic                       wr_en
);

  comb_state_t state;

  logic        [ADDR_W-1:0]     wr_ptr;
  logic signed [SAMPLE_W-1:0]   fb;
  logic signed [2*SAMPLE_W-1:0] prod;
  logic                         x_take;

  ////////////////////
  // Read request
  ////////////////////

  // Hold the read off while the tracker re-aims or the last write
  // is still landing, so the pointer and RAM word are both current
  assign rd_en   = (state == RD_REQ) && !ptr_busy && !wr_en;
  assign rd_addr = ptr_addr;

  // Full-width product, the Q_BITS slice below is the shift plus truncation
  assign prod = rd_data * gain;

  // A re-aim while waiting for x invalidates the fetched feedback term
  assign x_take = (state == WAIT_X) && !ptr_busy && x_valid;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RD_REQ;
      y_valid <= 1'b0;
      wr_en   <= 1'b0;
      wr_ptr  <= '0;
      wr_addr <= '0;
    end else begin
      y_valid <= 1'b0;
      wr_en   <= 1'b0;

      case (state)
        RD_REQ: begin
          if (rd_en) begin
            state <= RD_WAIT;
          end
        end

        RD_WAIT: begin
          if (rd_valid) begin
            state <= WAIT_X;
          end
        end

        WAIT_X: begin
          if (ptr_busy) begin
            state <= RD_REQ;
          end else if (x_take) begin
            y_valid <= 1'b1;
            state   <= WR_BACK;
          end
        end

        WR_BACK: begin
          wr_en   <= 1'b1;
          wr_addr <= wr_ptr;
          wr_ptr  <= wr_ptr + 1'b1;
          state   <= RD_REQ;
        end

        default: begin
          state <= RD_REQ;
        end
      endcase
    end
  end

  ////////////////////
  // Data path
  ////////////////////

  always_ff @(posedge clk) begin
    if (state == RD_WAIT && rd_valid) begin
      fb <= prod[Q_BITS +: SAMPLE_W];
    end
    // Sum wraps at the sample width
    if (x_take) begin
      y <= x + fb;
    end
    if (state == WR_BACK) begin
      wr_data <= y;
    end
  end

endmodule

//--- design/delay_ram.sv
module delay_ram import comb_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic        [ADDR_W-1:0]   wr_addr,
  input  logic signed [SAMPLE_W-1:0] wr_data,
  input  logic                       wr_en,
  input  logic        [ADDR_W-1:0]   rd_addr,
  input  logic                       rd_en,
  output logic signed [SAMPLE_W-1:0] rd_data,
  output logic                       rd_valid
);

  logic signed [SAMPLE_W-1:0] mem [RAM_DEPTH];

  // Words never written must read back as silence
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < RAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
      rd_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        mem[wr_addr] <= wr_data;
      end
      rd_valid <= rd_en;
    end
  end

  // One cycle of read latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- design/comb_echo_top.sv
module comb_echo_top import comb_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic signed [SAMPLE_W-1:0] x,
  input  logic                       x_valid,
  output logic signed [SAMPLE_W-1:0] y,
  output logic                       y_valid,
  input  logic        [DELAY_W-1:0]  delay,
  input  logic                       delay_load,
  input  logic signed [SAMPLE_W-1:0] gain
);

  logic        [ADDR_W-1:0]   ptr_addr;
  logic                       ptr_busy;
  logic        [ADDR_W-1:0]   rd_addr;
  logic                       rd_en;
  logic signed [SAMPLE_W-1:0] rd_data;
  logic                       rd_valid;
  logic        [ADDR_W-1:0]   wr_addr;
  logic signed [SAMPLE_W-1:0] wr_data;
  logic                       wr_en;

  ////////////////////
  // Input side
  ////////////////////

  delay_pointer u_ptr (
    .clk, .rst_n, .delay, .delay_load, .wr_en, .ptr_addr, .ptr_busy
  );

  ////////////////////
  // Processing
  ////////////////////

  comb_engine u_engine (
    .clk, .rst_n,
    .x, .x_valid, .gain, .y, .y_valid,
    .ptr_addr, .ptr_busy,
    .rd_addr, .rd_en, .rd_data, .rd_valid,
    .wr_addr, .wr_data, .wr_en
  );

  ////////////////////
  // Output side
  ////////////////////

  delay_ram u_ram (
    .clk, .rst_n,
    .wr_addr, .wr_data, .wr_en,
    .rd_addr, .rd_en, .rd_data, .rd_valid
  );

endmodule

//--- tb/comb_echo_asserts.sv
module comb_echo_asserts (
  input logic clk,
  input logic rst_n,
  input logic x_valid,
  input logic y_valid,
  input logic wr_en,
  input logic rd_en,
  input logic ptr_busy,
  input logic rd_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////
  // Sample strobes
  ////////////////////

  a_y_single: assert property (@(posedge clk) disable iff (!rst_n) y_valid |=> !y_valid)
    else $error("y_valid held longer than one cycle");

  a_y_after_x: assert property (@(posedge clk) disable iff (!rst_n) y_valid |-> $past(x_valid))
    else $error("y_valid without x_valid one cycle earlier");

  // Write-back lands one cycle after the output
  a_wr_after_y: assert property (@(posedge clk) disable iff (!rst_n) y_valid |=> wr_en)
    else $error("wr_en missing one cycle after y_valid");

  ////////////////////
  // Read path
  ////////////////////

  // The stalled read goes out as soon as the tracker settles
  a_rd_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
                                    $fell(ptr_busy) |-> rd_en)
    else $error("no read issued when the pointer tracker went idle");

  a_rd_valid: assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> rd_valid)
    else $error("rd_valid missing one cycle after rd_en");

endmodule

bind comb_engine comb_echo_asserts asserts0 (
  .clk, .rst_n, .x_valid, .y_valid, .wr_en, .rd_en, .ptr_busy, .rd_valid
);

//--- tb/comb_echo_tb.sv
module comb_echo_tb import comb_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Stimulus volume sets the timeout limit
  localparam int N_SAMPLES   = 20 + 64 + 30 + 100 + 60 + 60 + 200;
  localparam int N_LOADS     = 7;
  localparam int CYCLE_LIMIT = N_SAMPLES * 6 + N_LOADS * 8 + 200;

  localparam int S_MAX = (1 << (SAMPLE_W - 1)) - 1;
  localparam int S_MIN = -(1 << (SAMPLE_W - 1));

  logic                       clk;
  logic                       rst_n;
  logic signed [SAMPLE_W-1:0] x;
  logic                       x_valid;
  logic signed [SAMPLE_W-1:0] y;
  logic                       y_valid;
  logic        [DELAY_W-1:0]  delay;
  logic                       delay_load;
  logic signed [SAMPLE_W-1:0] gain;

  // Reference model state
  logic signed [SAMPLE_W-1:0] hist [RAM_DEPTH];
  int                         widx;
  int                         cur_delay;
  logic signed [SAMPLE_W-1:0] cur_gain;
  logic signed [SAMPLE_W-1:0] last_exp;
  bit                         wrapped;

  logic signed [SAMPLE_W-1:0] exp_q [$];
  int                         cycles;
  logic                       xv_prev;
  integer                     seed;

  comb_echo_top dut0 (
    .clk, .rst_n, .x, .x_valid, .y, .y_valid, .delay, .delay_load, .gain
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic signed [SAMPLE_W-1:0] expected_output(
    input logic signed [SAMPLE_W-1:0] xin,
    input int                         dly,
    input logic signed [SAMPLE_W-1:0] g
  );
    logic signed [SAMPLE_W-1:0] past;
    logic signed [SAMPLE_W-1:0] fbk;
    logic signed [SAMPLE_W-1:0] yout;
    longint                     prod;
    int                         sum;
    // Delay 64 reads the oldest word just before it is overwritten
    past = hist[(widx + RAM_DEPTH - dly) % RAM_DEPTH];
    prod = longint'(past) * longint'(g);
    fbk  = SAMPLE_W'(prod >>> Q_BITS);
    sum  = int'(xin) + int'(fbk);
    yout = SAMPLE_W'(sum);
    if (sum > S_MAX || sum < S_MIN) begin
      wrapped = 1'b1;
    end
    hist[widx] = yout;
    widx = (widx + 1) % RAM_DEPTH;
    return yout;
  endfunction

  function automatic logic signed [SAMPLE_W-1:0] random_sample(input int span);
    int v;
    v = $random(seed) % span;
    return SAMPLE_W'(v);
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_sample(
    input string                      name,
    input logic signed [SAMPLE_W-1:0] exp,
    input logic signed [SAMPLE_W-1:0] act
  );
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  task automatic check_strobe(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, act));
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_strobe("y_valid", xv_prev, y_valid);
      if (y_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("An output sample arrived with no input sample pending");
        end else begin
          check_sample("y", exp_q.pop_front(), y);
        end
      end
    end
    xv_prev = x_valid && rst_n;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run($sformatf("The run timed out after %0d clock cycles", cycles));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic send_sample(input logic signed [SAMPLE_W-1:0] v);
    @(posedge clk);
    x       <= v;
    x_valid <= 1'b1;
    last_exp = expected_output(v, cur_delay, cur_gain);
    exp_q.push_back(last_exp);
    @(posedge clk);
    x_valid <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic send_random(input int count);
    for (int i = 0; i < count; i++) begin
      send_sample(random_sample(8192));
    end
  endtask

  // Gain changes ride along with the load so the re-read picks them up
  task automatic load_delay(
    input logic        [DELAY_W-1:0]  d,
    input logic signed [SAMPLE_W-1:0] g
  );
    @(posedge clk);
    delay      <= d;
    gain       <= g;
    delay_load <= 1'b1;
    cur_delay = int'(d);
    cur_gain  = g;
    @(posedge clk);
    delay_load <= 1'b0;
    repeat (6) @(posedge clk);
  endtask

  initial begin
    seed      = 70619;
    widx      = 0;
    cur_delay = 0;
    cur_gain  = '0;
    wrapped   = 1'b0;
    cycles    = 0;
    xv_prev   = 1'b0;
    for (int i = 0; i < RAM_DEPTH; i++) begin
      hist[i] = '0;
    end
    rst_n      <= 1'b0;
    x          <= '0;
    x_valid    <= 1'b0;
    delay      <= '0;
    delay_load <= 1'b0;
    gain       <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Pass-through with zero gain
    load_delay(7'd1, '0);
    send_random(20);

    // Flush the delay line with silence before the impulse
    load_delay(7'd5, '0);
    for (int i = 0; i < 64; i++) begin
      send_sample('0);
    end

    // Impulse echo halves every 5 samples
    load_delay(7'd5, SAMPLE_W'(2048));
    for (int i = 0; i < 30; i++) begin
      send_sample((i == 0) ? SAMPLE_W'(4096) : '0);
      check_sample("impulse_echo", (i % 5 == 0) ? SAMPLE_W'(4096 >> (i / 5)) : '0,
                   last_exp);
    end

    // Negative gain
    load_delay(7'd17, SAMPLE_W'(-3072));
    send_random(100);

    // Longer then shorter delay mid-stream
    load_delay(7'd40, SAMPLE_W'(-3072));
    send_random(60);
    load_delay(7'd3, SAMPLE_W'(-3072));
    send_random(60);

    // Large inputs at unity gain and full depth pile up past full scale
    load_delay(7'd64, SAMPLE_W'(4096));
    for (int i = 0; i < 200; i++) begin
      send_sample(SAMPLE_W'(12000) + random_sample(256));
    end

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    if (!wrapped) begin
      abort_run("The sum never crossed full scale, so wrapping was not exercised");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- comb_echo.f
design/comb_pkg.sv
design/delay_pointer.sv
design/comb_engine.sv
design/delay_ram.sv
design/comb_echo_top.sv
tb/comb_echo_asserts.sv
tb/comb_echo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= comb_echo_tb
FILELIST  ?= comb_echo.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
